//--- Bender.yml
package:
  name: debug_unit

export_include_dirs:
  - src

sources:
  - files:
      - src/debug_unit_pkg.sv
      - src/dump_address_counter.sv
      - src/debug_command_fsm.sv
      - src/debug_tx_register.sv
      - src/program_loader.sv
      - src/debug_unit_top.sv
  - target: test
    files:
      - tests/debug_unit_tb.sv

//--- src/debug_command_fsm.sv
`timescale 1ns/1ns
`default_nettype none

`include "debug_unit_defs.svh"

module debug_command_fsm (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_fifo_empty,
    input  debug_unit_pkg::byte_t       i_command,
    input  logic                        i_is_end,
    input  logic                        i_tx_done,
    input  logic                        i_reg_last,
    input  logic                        i_mem_last,
    input  logic                        i_program_loaded,
    output logic [`DU_N_STAGES-1:0]     o_stage_enable,
    output logic                        o_pc_reset,
    output logic                        o_delete_program,
    output logic                        o_reg_clear,
    output logic                        o_reg_advance,
    output logic                        o_mem_clear,
    output logic                        o_mem_advance,
    output logic                        o_tx_load,
    output debug_unit_pkg::tx_source_t  o_tx_source,
    output logic                        o_load_active,
    output logic                        o_flush
);

    typedef enum logic [1:0] {sub_setup, sub_send, sub_wait, sub_advance} dump_sub_t;

    debug_unit_pkg::du_state_t  state;
    debug_unit_pkg::du_state_t  state_next;
    dump_sub_t                  substate;
    dump_sub_t                  substate_next;

    logic [`DU_N_STAGES-1:0]    stage_enable_next;
    logic                       pc_reset_next;
    logic                       delete_program_next;
    logic                       is_reg_dump;
    logic                       dump_last;  // Word at last address of active dump

    assign is_reg_dump = (state == debug_unit_pkg::st_reg_dump);
    assign dump_last   = is_reg_dump ? i_reg_last : i_mem_last;

    // ------------------------------------------------------------
    // State and registered outputs
    // ------------------------------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state            <= debug_unit_pkg::st_idle;
            substate         <= sub_setup;
            o_stage_enable   <= '0;
            o_pc_reset       <= 1'b0;
            o_delete_program <= 1'b0;
        end else begin
            state            <= state_next;
            substate         <= substate_next;
            o_stage_enable   <= stage_enable_next;
            o_pc_reset       <= pc_reset_next;
            o_delete_program <= delete_program_next;
        end
    end

    // ------------------------------------------------------------
    // Command decoding and sequencing
    // ------------------------------------------------------------
    always_comb begin
        state_next          = state;
        substate_next       = substate;
        stage_enable_next   = '0;
        pc_reset_next       = 1'b0;
        delete_program_next = 1'b0;
        o_reg_clear         = 1'b0;
        o_reg_advance       = 1'b0;
        o_mem_clear         = 1'b0;
        o_mem_advance       = 1'b0;
        o_tx_load           = 1'b0;
        o_tx_source         = debug_unit_pkg::tx_src_reg;
        o_load_active       = 1'b0;
        o_flush             = 1'b0;

        case (state)
            debug_unit_pkg::st_idle: begin
                substate_next = sub_setup;
                if (!i_fifo_empty) begin
                    case (i_command)
                        `DU_CMD_RUN:      state_next = debug_unit_pkg::st_run;
                        `DU_CMD_STEP:     state_next = debug_unit_pkg::st_step;
                        `DU_CMD_READ_REG: state_next = debug_unit_pkg::st_reg_dump;
                        `DU_CMD_READ_MEM: state_next = debug_unit_pkg::st_mem_dump;
                        `DU_CMD_READ_PC:  state_next = debug_unit_pkg::st_read_pc;
                        `DU_CMD_RESET_PC: state_next = debug_unit_pkg::st_reset_pc;
                        `DU_CMD_FLUSH:    state_next = debug_unit_pkg::st_flush;
                        `DU_CMD_LOAD:     state_next = debug_unit_pkg::st_load;
                        default:          state_next = debug_unit_pkg::st_idle;
                    endcase
                end
            end

            debug_unit_pkg::st_run: begin
                if (!i_is_end) begin
                    stage_enable_next = '1;
                end else begin
                    state_next = debug_unit_pkg::st_idle;
                end
            end

            debug_unit_pkg::st_step: begin
                if (!i_is_end) begin
                    stage_enable_next = '1;  // Single clock of the pipeline
                end
                state_next = debug_unit_pkg::st_idle;
            end

            debug_unit_pkg::st_reg_dump, debug_unit_pkg::st_mem_dump: begin
                case (substate)
                    sub_setup: begin
                        o_reg_clear   = is_reg_dump;
                        o_mem_clear   = !is_reg_dump;
                        substate_next = sub_send;
                    end
                    sub_send: begin
                        o_tx_load     = 1'b1;
                        o_tx_source   = is_reg_dump ? debug_unit_pkg::tx_src_reg
                                                    : debug_unit_pkg::tx_src_mem;
                        substate_next = sub_wait;
                    end
                    sub_wait: begin
                        if (i_tx_done) begin
                            substate_next = sub_advance;
                        end
                    end
                    sub_advance: begin
                        // Counter wraps to 0 after the last address
                        o_reg_advance = is_reg_dump;
                        o_mem_advance = !is_reg_dump;
                        if (dump_last) begin
                            state_next    = debug_unit_pkg::st_idle;
                            substate_next = sub_setup;
                        end else begin
                            substate_next = sub_send;
                        end
                    end
                    default: substate_next = sub_setup;
                endcase
            end

            debug_unit_pkg::st_read_pc: begin
                o_tx_load   = 1'b1;
                o_tx_source = debug_unit_pkg::tx_src_pc;
                state_next  = debug_unit_pkg::st_idle;
            end

            debug_unit_pkg::st_reset_pc: begin
                pc_reset_next = 1'b1;
                state_next    = debug_unit_pkg::st_idle;
            end

            debug_unit_pkg::st_flush: begin
                pc_reset_next       = 1'b1;
                delete_program_next = 1'b1;
                o_flush             = 1'b1;
                state_next          = debug_unit_pkg::st_idle;
            end

            debug_unit_pkg::st_load: begin
                if (i_program_loaded) begin
                    state_next = debug_unit_pkg::st_idle;  // Marker seen or already loaded
                end else begin
                    o_load_active = 1'b1;
                end
            end

            default: state_next = debug_unit_pkg::st_idle;
        endcase
    end

    // Next dump word only once the previous one went out
    a_advance_after_done: assert property (@(posedge i_clock) disable iff (i_reset)
        (o_reg_advance || o_mem_advance) |-> $past(i_tx_done));

endmodule

`default_nettype wire

//--- src/debug_tx_register.sv
`timescale 1ns/1ns
`default_nettype none

module debug_tx_register (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_load,
    input  debug_unit_pkg::tx_source_t  i_source,
    input  debug_unit_pkg::word_t       i_reg_data,
    input  debug_unit_pkg::word_t       i_mem_data,
    input  debug_unit_pkg::word_t       i_pc,
    output logic                        o_send,
    output debug_unit_pkg::word_t       o_send_word
);

    debug_unit_pkg::word_t selected_word;

    always_comb begin
        case (i_source)
            debug_unit_pkg::tx_src_reg: selected_word = i_reg_data;
            debug_unit_pkg::tx_src_mem: selected_word = i_mem_data;
            default:                    selected_word = i_pc;
        endcase
    end

    // One-cycle send strobe
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_send <= 1'b0;
        end else begin
            o_send <= i_load;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_load) begin
            o_send_word <= selected_word;  // Held until next load
        end
    end

endmodule

`default_nettype wire

//--- src/debug_unit_defs.svh
`ifndef DEBUG_UNIT_DEFS_SVH
`define DEBUG_UNIT_DEFS_SVH

// Datapath widths
`define DU_WORD_BITS      32
`define DU_BYTE_BITS      8
`define DU_REG_ADDR_BITS  5
`define DU_MEM_ADDR_BITS  7
`define DU_N_STAGES       5   // Stage latch enables

// Dump ranges
`define DU_REG_LAST       31
`define DU_MEM_STEP       4   // Bytes per memory word
`define DU_MEM_LAST       124

// Serial commands
`define DU_CMD_RUN        "E"
`define DU_CMD_STEP       "N"
`define DU_CMD_READ_REG   "R"
`define DU_CMD_READ_MEM   "M"
`define DU_CMD_READ_PC    "P"
`define DU_CMD_RESET_PC   "C"
`define DU_CMD_FLUSH      "D"
`define DU_CMD_LOAD       "L"

`define DU_END_MARK_BIT   6   // In first byte of an instruction

`endif

//--- src/debug_unit_pkg.sv
`default_nettype none

`include "debug_unit_defs.svh"

package debug_unit_pkg;

    typedef logic [`DU_WORD_BITS-1:0] word_t;
    typedef logic [`DU_BYTE_BITS-1:0] byte_t;

    typedef enum logic [3:0] {
        st_idle,
        st_run,
        st_step,
        st_reg_dump,
        st_mem_dump,
        st_read_pc,
        st_reset_pc,
        st_flush,
        st_load
    } du_state_t;

    // Word picked by the transmit register
    typedef enum logic [1:0] {tx_src_reg, tx_src_mem, tx_src_pc} tx_source_t;

endpackage

`default_nettype wire

//--- src/debug_unit_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "debug_unit_defs.svh"

module debug_unit_top (
    input  logic                          i_clock,
    input  logic                          i_reset,
    input  logic                          i_fifo_empty,
    input  debug_unit_pkg::byte_t         i_command,
    input  logic                          i_is_end,
    input  logic                          i_tx_done,
    input  debug_unit_pkg::word_t         i_reg_data,
    input  debug_unit_pkg::word_t         i_mem_data,
    input  debug_unit_pkg::word_t         i_pc,
    output logic [`DU_N_STAGES-1:0]       o_stage_enable,
    output logic                          o_send,
    output debug_unit_pkg::word_t         o_send_word,
    output logic [`DU_REG_ADDR_BITS-1:0]  o_reg_address,
    output logic [`DU_MEM_ADDR_BITS-1:0]  o_mem_address,
    output logic                          o_pc_reset,
    output logic                          o_delete_program,
    output logic                          o_load_write,
    output debug_unit_pkg::byte_t         o_load_byte,
    output logic                          o_program_loaded
);

    logic                        reg_clear;
    logic                        reg_advance;
    logic                        reg_last;
    logic                        mem_clear;
    logic                        mem_advance;
    logic                        mem_last;
    logic                        tx_load;
    debug_unit_pkg::tx_source_t  tx_source;
    logic                        load_active;
    logic                        flush;

    debug_command_fsm command_fsm_i (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_fifo_empty     (i_fifo_empty),
        .i_command        (i_command),
        .i_is_end         (i_is_end),
        .i_tx_done        (i_tx_done),
        .i_reg_last       (reg_last),
        .i_mem_last       (mem_last),
        .i_program_loaded (o_program_loaded),
        .o_stage_enable   (o_stage_enable),
        .o_pc_reset       (o_pc_reset),
        .o_delete_program (o_delete_program),
        .o_reg_clear      (reg_clear),
        .o_reg_advance    (reg_advance),
        .o_mem_clear      (mem_clear),
        .o_mem_advance    (mem_advance),
        .o_tx_load        (tx_load),
        .o_tx_source      (tx_source),
        .o_load_active    (load_active),
        .o_flush          (flush)
    );

    // Register dump walks every register
    dump_address_counter #(
        .WIDTH (`DU_REG_ADDR_BITS),
        .STEP  (1),
        .LAST  (`DU_REG_LAST)
    ) reg_counter (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_clear   (reg_clear),
        .i_advance (reg_advance),
        .o_address (o_reg_address),
        .o_last    (reg_last)
    );

    // Memory dump walks byte addresses one word apart
    dump_address_counter #(
        .WIDTH (`DU_MEM_ADDR_BITS),
        .STEP  (`DU_MEM_STEP),
        .LAST  (`DU_MEM_LAST)
    ) mem_counter (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_clear   (mem_clear),
        .i_advance (mem_advance),
        .o_address (o_mem_address),
        .o_last    (mem_last)
    );

    debug_tx_register tx_register_i (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_load      (tx_load),
        .i_source    (tx_source),
        .i_reg_data  (i_reg_data),
        .i_mem_data  (i_mem_data),
        .i_pc        (i_pc),
        .o_send      (o_send),
        .o_send_word (o_send_word)
    );

    program_loader program_loader_i (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_active         (load_active),
        .i_flush          (flush),
        .i_fifo_empty     (i_fifo_empty),
        .i_byte           (i_command),
        .o_load_write     (o_load_write),
        .o_load_byte      (o_load_byte),
        .o_program_loaded (o_program_loaded)
    );

endmodule

`default_nettype wire

//--- src/dump_address_counter.sv
`timescale 1ns/1ns
`default_nettype none

module dump_address_counter #(
    parameter int WIDTH = 5,
    parameter int STEP  = 1,
    parameter int LAST  = 31
) (
    input  logic             i_clock,
    input  logic             i_reset,
    input  logic             i_clear,
    input  logic             i_advance,
    output logic [WIDTH-1:0] o_address,
    output logic             o_last
);

    localparam logic [WIDTH-1:0] STEP_W = WIDTH'(STEP);
    localparam logic [WIDTH-1:0] LAST_W = WIDTH'(LAST);

    // ------------------------------------------------------------
    // Address register
    // ------------------------------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_reset || i_clear) begin
            o_address <= '0;
        end else if (i_advance) begin
            if (o_last) begin
                o_address <= '0;  // Dump complete
            end else begin
                o_address <= o_address + STEP_W;
            end
        end
    end

    assign o_last = (o_address == LAST_W);

    // Clear and advance come from different dump substates
    a_clear_advance_excl: assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_clear && i_advance));

endmodule

`default_nettype wire

//--- src/program_loader.sv
`timescale 1ns/1ns
`default_nettype none

`include "debug_unit_defs.svh"

module program_loader (
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_active,
    input  logic                   i_flush,
    input  logic                   i_fifo_empty,
    input  debug_unit_pkg::byte_t  i_byte,
    output logic                   o_load_write,
    output debug_unit_pkg::byte_t  o_load_byte,
    output logic                   o_program_loaded
);

    logic [1:0] byte_count;  // Byte position inside the instruction
    logic       take_byte;
    logic       end_mark;

    assign take_byte = i_active && !i_fifo_empty && !o_program_loaded;
    assign end_mark  = take_byte && (byte_count == 2'd0) && i_byte[`DU_END_MARK_BIT];

    // ------------------------------------------------------------
    // Byte counter, write strobe and loaded flag
    // ------------------------------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            byte_count       <= 2'd0;
            o_load_write     <= 1'b0;
            o_program_loaded <= 1'b0;
        end else begin
            o_load_write <= take_byte && !end_mark;  // Marker itself is not stored

            if (!i_active || i_flush) begin
                byte_count <= 2'd0;
            end else if (take_byte) begin
                byte_count <= byte_count + 2'd1;
            end

            if (i_flush) begin
                o_program_loaded <= 1'b0;
            end else if (end_mark) begin
                o_program_loaded <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (take_byte) begin
            o_load_byte <= i_byte;
        end
    end

    // Flush and loading come from different commands
    a_no_flush_while_active: assert property (@(posedge i_clock) disable iff (i_reset)
        i_flush |-> !i_active);

endmodule

`default_nettype wire

//--- tests/debug_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "debug_unit_defs.svh"

module debug_unit_tb;

    // Two dumps of 32 words at up to 11 cycles each, loads and short tests on top
    localparam int TIMEOUT_CYCLES = 5000;

    logic                          i_clock;
    logic                          i_reset;
    logic                          i_fifo_empty;
    debug_unit_pkg::byte_t         i_command;
    logic                          i_is_end;
    logic                          i_tx_done;
    debug_unit_pkg::word_t         i_reg_data;
    debug_unit_pkg::word_t         i_mem_data;
    debug_unit_pkg::word_t         i_pc;
    logic [`DU_N_STAGES-1:0]       o_stage_enable;
    logic                          o_send;
    debug_unit_pkg::word_t         o_send_word;
    logic [`DU_REG_ADDR_BITS-1:0]  o_reg_address;
    logic [`DU_MEM_ADDR_BITS-1:0]  o_mem_address;
    logic                          o_pc_reset;
    logic                          o_delete_program;
    logic                          o_load_write;
    debug_unit_pkg::byte_t         o_load_byte;
    logic                          o_program_loaded;

    debug_unit_pkg::word_t reg_model [0:`DU_REG_LAST];
    debug_unit_pkg::word_t mem_model [0:(1 << `DU_MEM_ADDR_BITS)-1];

    // Expected traffic, appended by the tests and consumed at each pulse
    debug_unit_pkg::word_t expected_words [0:127];
    debug_unit_pkg::byte_t expected_bytes [0:127];
    debug_unit_pkg::word_t expected_word;
    debug_unit_pkg::byte_t expected_byte;
    int expected_word_count = 0;
    int expected_byte_count = 0;
    int send_index = 0;
    int write_index = 0;

    logic        tx_pending = 1'b0;  // Word sent, tx done not yet returned
    int          tx_countdown = 0;
    int          enable_total = 0;
    int          pc_reset_total = 0;
    int          delete_total = 0;
    int          cycle_count = 0;
    logic [31:0] lcg_state = 32'd19335;

    string test_name = "reset";
    int    error_count = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    error_mark;
    int    enable_mark;
    int    pc_reset_mark;
    int    delete_mark;

    assign expected_word = expected_words[send_index];
    assign expected_byte = expected_bytes[write_index];
    assign i_reg_data    = reg_model[o_reg_address];  // Combinational register file read
    assign i_mem_data    = mem_model[o_mem_address];

    debug_unit_top debug_unit_top_i (.*);

    initial begin
        i_clock = 1'b0;
        forever #2 i_clock = ~i_clock;
    end

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles, test %s never finished", cycle_count,
                     test_name);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Serial transmitter model and traffic monitor
    // ------------------------------------------------------------
    always @(negedge i_clock) begin
        if (i_reset) begin
            tx_countdown = 0;
            i_tx_done    = 1'b0;
        end else begin
            i_tx_done = 1'b0;
            if (o_send) begin
                tx_countdown = 1 + random_below(8);
            end else if (tx_countdown > 0) begin
                tx_countdown = tx_countdown - 1;
                i_tx_done    = (tx_countdown == 0);
            end
        end
    end

    always @(posedge i_clock) begin
        if (!i_reset) begin
            if (o_send) begin
                send_index <= send_index + 1;
                tx_pending <= 1'b1;
            end else if (i_tx_done) begin
                tx_pending <= 1'b0;
            end
            if (o_load_write) write_index <= write_index + 1;
            if (o_stage_enable != '0) enable_total <= enable_total + 1;
            if (o_pc_reset) pc_reset_total <= pc_reset_total + 1;
            if (o_delete_program) delete_total <= delete_total + 1;
        end
    end

    a_send_expected: assert property (@(posedge i_clock) disable iff (i_reset)
        o_send |-> (send_index < expected_word_count))
        else begin
            $display("Error in %s: send pulse with no word expected", test_name);
            error_count++;
        end

    a_send_word: assert property (@(posedge i_clock) disable iff (i_reset)
        (o_send && (send_index < expected_word_count)) |-> (o_send_word == expected_word))
        else begin
            $display("[ERROR] %s: send word expected %h, actual %h", test_name,
                     $sampled(expected_word), $sampled(o_send_word));
            error_count++;
        end

    a_send_after_done: assert property (@(posedge i_clock) disable iff (i_reset)
        o_send |-> !tx_pending)
        else begin
            $display("Error in %s: new word sent before tx done", test_name);
            error_count++;
        end

    a_enable_whole: assert property (@(posedge i_clock) disable iff (i_reset)
        (o_stage_enable == '0) || (o_stage_enable == '1))
        else begin
            $display("Error in %s: only some stage enables raised", test_name);
            error_count++;
        end

    a_delete_with_reset: assert property (@(posedge i_clock) disable iff (i_reset)
        o_delete_program |-> o_pc_reset)
        else begin
            $display("Error in %s: program deleted without PC reset", test_name);
            error_count++;
        end

    a_write_expected: assert property (@(posedge i_clock) disable iff (i_reset)
        o_load_write |-> (write_index < expected_byte_count))
        else begin
            $display("Error in %s: boot memory write with no byte expected", test_name);
            error_count++;
        end

    a_write_byte: assert property (@(posedge i_clock) disable iff (i_reset)
        (o_load_write && (write_index < expected_byte_count)) |->
            (o_load_byte == expected_byte))
        else begin
            $display("[ERROR] %s: load byte expected %h, actual %h", test_name,
                     $sampled(expected_byte), $sampled(o_load_byte));
            error_count++;
        end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int random_below(input int n);
        return int'((next_random() >> 16) % n);  // Upper bits, low ones cycle fast
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected)
            else begin
                $display("[ERROR] %s: %s expected %0d, actual %0d", test_name, what,
                         expected, actual);
                error_count++;
            end
    endtask

    task automatic present_byte(input debug_unit_pkg::byte_t value);
        @(negedge i_clock);
        i_fifo_empty = 1'b0;
        i_command    = value;
    endtask

    task automatic release_fifo();
        @(negedge i_clock);
        i_fifo_empty = 1'b1;
    endtask

    task automatic send_command(input debug_unit_pkg::byte_t value);
        present_byte(value);
        release_fifo();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge i_clock);
    endtask

    task automatic expect_word(input debug_unit_pkg::word_t value);
        expected_words[expected_word_count] = value;
        expected_word_count++;
    endtask

    task automatic expect_byte(input debug_unit_pkg::byte_t value);
        expected_bytes[expected_byte_count] = value;
        expected_byte_count++;
    endtask

    task automatic wait_for_sends();
        while ((send_index < expected_word_count) || tx_pending) @(negedge i_clock);
    endtask

    // L, whole instructions with random gaps, then the end marker
    task automatic stream_program(input int n_instr);
        debug_unit_pkg::byte_t value;
        int                    i;
        present_byte(`DU_CMD_LOAD);
        for (i = 0; i < 4 * n_instr; i++) begin
            value = debug_unit_pkg::byte_t'(next_random() >> 16);
            if (i % 4 == 0) value[`DU_END_MARK_BIT] = 1'b0;
            expect_byte(value);
            if (random_below(4) == 0) release_fifo();
            present_byte(value);
        end
        value = debug_unit_pkg::byte_t'(next_random() >> 16);
        value[`DU_END_MARK_BIT] = 1'b1;
        present_byte(value);
        release_fifo();
        while (!o_program_loaded) @(negedge i_clock);
    endtask

    task automatic test_begin(input string name);
        test_name     = name;
        error_mark    = error_count;
        enable_mark   = enable_total;
        pc_reset_mark = pc_reset_total;
        delete_mark   = delete_total;
    endtask

    task automatic test_end(input int n_enable, input int n_pc_reset, input int n_delete);
        check_value("stage enable cycles", n_enable, enable_total - enable_mark);
        check_value("pc reset pulses", n_pc_reset, pc_reset_total - pc_reset_mark);
        check_value("delete pulses", n_delete, delete_total - delete_mark);
        check_value("send pulses so far", expected_word_count, send_index);
        check_value("load writes so far", expected_byte_count, write_index);
        tests_run++;
        if (error_count == error_mark) begin
            $display("test %-18s ok", test_name);
        end else begin
            tests_failed++;
            $display("test %-18s %0d errors", test_name, error_count - error_mark);
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        int run_len;
        int a;
        i_reset      = 1'b1;
        i_fifo_empty = 1'b1;
        i_command    = '0;
        i_is_end     = 1'b0;
        i_tx_done    = 1'b0;
        i_pc         = '0;
        for (a = 0; a <= `DU_REG_LAST; a++) reg_model[a] = next_random();
        for (a = 0; a < (1 << `DU_MEM_ADDR_BITS); a++) mem_model[a] = next_random();
        repeat (16) @(posedge i_clock);
        @(negedge i_clock);
        i_reset = 1'b0;

        test_begin("after_reset");
        check_value("stage enable", 0, o_stage_enable);
        check_value("send", 0, o_send);
        check_value("pc reset", 0, o_pc_reset);
        check_value("delete program", 0, o_delete_program);
        check_value("load write", 0, o_load_write);
        check_value("program loaded", 0, o_program_loaded);
        check_value("reg address", 0, o_reg_address);
        check_value("mem address", 0, o_mem_address);
        test_end(0, 0, 0);

        test_begin("unknown_command");
        send_command(8'h5A);
        idle_cycles(6);
        test_end(0, 0, 0);

        test_begin("step");
        send_command(`DU_CMD_STEP);
        idle_cycles(4);
        test_end(1, 0, 0);

        test_begin("step_at_end");
        i_is_end = 1'b1;
        send_command(`DU_CMD_STEP);
        idle_cycles(4);
        i_is_end = 1'b0;
        test_end(0, 0, 0);

        test_begin("run");
        run_len = 3 + random_below(20);
        send_command(`DU_CMD_RUN);
        while (o_stage_enable == '0) @(negedge i_clock);
        idle_cycles(run_len);
        i_is_end = 1'b1;  // Enables drop at the next edge
        idle_cycles(4);
        i_is_end = 1'b0;
        test_end(run_len + 1, 0, 0);

        test_begin("reg_dump");
        for (a = 0; a <= `DU_REG_LAST; a++) expect_word(reg_model[a]);
        send_command(`DU_CMD_READ_REG);
        wait_for_sends();
        idle_cycles(4);
        check_value("reg address", 0, o_reg_address);
        test_end(0, 0, 0);

        test_begin("mem_dump");
        for (a = 0; a <= `DU_MEM_LAST; a += `DU_MEM_STEP) expect_word(mem_model[a]);
        send_command(`DU_CMD_READ_MEM);
        wait_for_sends();
        idle_cycles(4);
        check_value("mem address", 0, o_mem_address);
        test_end(0, 0, 0);

        test_begin("read_pc");
        i_pc = next_random();
        expect_word(i_pc);
        send_command(`DU_CMD_READ_PC);
        wait_for_sends();
        idle_cycles(2);
        test_end(0, 0, 0);

        test_begin("reset_pc");
        send_command(`DU_CMD_RESET_PC);
        idle_cycles(4);
        test_end(0, 1, 0);

        test_begin("load");
        stream_program(8);
        idle_cycles(3);
        check_value("program loaded", 1, o_program_loaded);
        test_end(0, 0, 0);

        test_begin("load_when_loaded");
        present_byte(`DU_CMD_LOAD);
        present_byte(8'h13);
        release_fifo();
        idle_cycles(4);
        check_value("program loaded", 1, o_program_loaded);
        test_end(0, 0, 0);

        test_begin("flush");
        send_command(`DU_CMD_FLUSH);
        idle_cycles(4);
        check_value("program loaded", 0, o_program_loaded);
        test_end(0, 1, 1);

        test_begin("reload");
        stream_program(3);
        idle_cycles(3);
        check_value("program loaded", 1, o_program_loaded);
        test_end(0, 0, 0);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+src
src/debug_unit_pkg.sv
src/dump_address_counter.sv
src/debug_command_fsm.sv
src/debug_tx_register.sv
src/program_loader.sv
src/debug_unit_top.sv
tests/debug_unit_tb.sv
